// File: list.f
+incdir+rtl
rtl/transmit_pkg.sv
rtl/config_regs.sv
rtl/waveform_player.sv
rtl/triangle_gen.sv
rtl/source_select.sv
rtl/sample_scaler.sv
rtl/transmit_top.sv
bench/transmit_top_tb.sv

// File: bench/transmit_cases.txt
# records: write <addr hex> <data hex> | random <ch> <count> | wait <cycles>
# expect idle <cycles> | expect wave <ch> | expect tri <ch> <cycles> | test <name> ... done
test reset_idle
expect idle 20
done
test wave_play
random 0 16
write 030 10
write 040 2
write 020 10000
write 010 1
write 050 1
write 060 1
expect wave 0
done
test trigger_mask
write 050 0
write 060 1
expect wave 0
done
test triangle
write 000 01000000
write 010 2
wait 5
expect tri 0 600
done
test scale_half
random 0 16
write 010 1
write 020 8000
write 050 1
wait 5
write 060 1
expect wave 0
done
test scale_double
write 020 20000
write 060 1
expect wave 0
done
test two_channels
write 011 2
write 021 10000
write 001 01000000
write 060 1
expect wave 0
expect tri 1 600
done

// File: bench/transmit_top_tb.sv
// testbench for the DAC transmit chain
// reads config writes and expectations from the case file and checks DAC outputs
`timescale 1ns/1ns
`include "transmit_settings.svh"

module transmit_top_tb;
  import transmit_pkg::*;

  logic dac_clk;
  logic ps_reset;
  cfg_write_t cfg;
  sample_t [`CHANNELS-1:0] dac_data;
  logic [`CHANNELS-1:0] dac_valid;
  logic dac_trigger;

  // register and waveform model built from the driven writes
  int wave_model [`CHANNELS][`WAVE_DEPTH];
  int scale_model [`CHANNELS];
  int depth_model [`CHANNELS];
  int burst_model [`CHANNELS];
  int sel_model [`CHANNELS];
  logic [31:0] inc_model [`CHANNELS];
  logic [`CHANNELS-1:0] mask_model;

  int test_errors;
  int stray_errors;
  int tests_passed;
  int tests_failed;

  transmit_top i_dut (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .cfg(cfg),
    .dac_data(dac_data),
    .dac_valid(dac_valid),
    .dac_trigger(dac_trigger)
  );

  always #50 dac_clk = ~dac_clk;

  // inputs change and outputs are read 1 ns after each rising edge
  task automatic next_cycle;
    @(posedge dac_clk);
    #1;
  endtask

  task automatic note_error(input string msg);
    $display("%s", msg);
    test_errors++;
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] want,
                                 input logic [31:0] got);
    note_error($sformatf("CHECK FAILED %s expected %h actual %h", sig, want, got));
  endtask

  // floor of sample times scale over 2^16, clamped to the sample range
  function automatic int scaled_value(input int s, input int sc);
    longint p;
    p = longint'(s) * longint'(sc);
    p = p >>> `SCALE_FRAC_BITS;
    if (p > 32767) p = 32767;
    if (p < -32768) p = -32768;
    return int'(p);
  endfunction

  task automatic drive_write(input int addr, input logic [31:0] data);
    int off;
    off = addr - 'h400;
    cfg.valid = 1'b1;
    cfg.address = addr[`CFG_ADDR_WIDTH-1:0];
    cfg.data = data;
    if (off >= 0 && off < `CHANNELS * `WAVE_DEPTH) begin
      wave_model[off / `WAVE_DEPTH][off % `WAVE_DEPTH] = $signed(data[15:0]);
    end
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      if (addr == 'h000 + ch) inc_model[ch] = data;
      if (addr == 'h010 + ch) sel_model[ch] = data[1:0];
      if (addr == 'h020 + ch) scale_model[ch] = data[17:0];
      if (addr == 'h030 + ch) depth_model[ch] = data[6:0];
      if (addr == 'h040 + ch) burst_model[ch] = data[15:0];
    end
    if (addr == 'h050) mask_model = data[`CHANNELS-1:0];
    next_cycle();
    cfg.valid = 1'b0;
  endtask

  task automatic wait_for_valid(input int ch, output bit seen);
    int cycles;
    cycles = 0;
    while (!dac_valid[ch] && cycles < 40) begin
      next_cycle();
      cycles++;
    end
    seen = dac_valid[ch];
    if (!seen) note_error($sformatf("timed out waiting for dac_valid on channel %0d", ch));
  endtask

  task automatic check_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      if (dac_valid !== '0) report_mismatch("dac_valid", 0, dac_valid);
      if (dac_trigger !== 1'b0) report_mismatch("dac_trigger", 0, dac_trigger);
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        if (dac_data[ch] !== '0) report_mismatch($sformatf("dac_data[%0d]", ch), 0, dac_data[ch]);
      end
      next_cycle();
    end
  endtask

  // waveform frames on one channel with triangle channels watched alongside
  task automatic check_wave(input int ch);
    int total;
    int want;
    int cur;
    int lim;
    int oc;
    bit seen;
    bit want_trig;
    int last_tri [`CHANNELS];
    total = depth_model[ch] * burst_model[ch];
    wait_for_valid(ch, seen);
    if (seen) begin
      for (oc = 0; oc < `CHANNELS; oc++) last_tri[oc] = dac_data[oc];
      for (int n = 0; n < total; n++) begin
        if (n > 0) next_cycle();
        want = scaled_value(wave_model[ch][n % depth_model[ch]], scale_model[ch]);
        want_trig = mask_model[ch] && (n % depth_model[ch] == 0);
        if (dac_valid[ch] !== 1'b1) begin
          report_mismatch($sformatf("dac_valid[%0d]", ch), 1, dac_valid[ch]);
        end
        if (dac_data[ch] !== want[15:0]) begin
          report_mismatch($sformatf("dac_data[%0d]", ch), want[15:0], dac_data[ch]);
        end
        if (dac_trigger !== want_trig) report_mismatch("dac_trigger", want_trig, dac_trigger);
        for (oc = 0; oc < `CHANNELS; oc++) begin
          if (oc != ch && sel_model[oc] == 2) begin
            cur = dac_data[oc];
            lim = (inc_model[oc] >> 15) + 1;
            if (dac_valid[oc] !== 1'b1) begin
              report_mismatch($sformatf("dac_valid[%0d]", oc), 1, dac_valid[oc]);
            end
            if (cur - last_tri[oc] > lim || last_tri[oc] - cur > lim) begin
              note_error($sformatf("CHECK FAILED dac_data[%0d] step from %h to %h",
                                   oc, last_tri[oc][15:0], cur[15:0]));
            end
            last_tri[oc] = cur;
          end
        end
      end
      next_cycle();
      if (dac_valid[ch] !== 1'b0) begin
        report_mismatch($sformatf("dac_valid[%0d]", ch), 0, dac_valid[ch]);
      end
    end
  endtask

  task automatic check_triangle(input int ch, input int cycles);
    int lim;
    int prev;
    int cur;
    int dir;
    int lo;
    int hi;
    bit seen;
    lim = (inc_model[ch] >> 15) + 1;
    dir = 0;
    wait_for_valid(ch, seen);
    if (seen) begin
      prev = dac_data[ch];
      lo = prev;
      hi = prev;
      for (int i = 1; i < cycles; i++) begin
        next_cycle();
        cur = dac_data[ch];
        if (dac_valid[ch] !== 1'b1) begin
          report_mismatch($sformatf("dac_valid[%0d]", ch), 1, dac_valid[ch]);
        end
        if (cur - prev > lim || prev - cur > lim) begin
          note_error($sformatf("CHECK FAILED dac_data[%0d] step from %h to %h",
                               ch, prev[15:0], cur[15:0]));
        end
        if (cur != prev) begin
          // turning point must sit near full scale
          if (dir != 0 && (cur > prev) != (dir > 0) &&
              prev < 32767 - lim && prev > -32768 + lim) begin
            note_error($sformatf("triangle on channel %0d turned away from the extremes", ch));
          end
          dir = (cur > prev) ? 1 : -1;
        end
        if (cur < lo) lo = cur;
        if (cur > hi) hi = cur;
        prev = cur;
      end
      if (hi < 32767 - lim || lo > -32768 + lim) begin
        note_error($sformatf("triangle on channel %0d did not reach both extremes", ch));
      end
    end
  endtask

  initial begin
    #1000000;
    $display("simulation time limit reached before the case file finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int fd;
    int addr;
    int ch;
    int count;
    logic [31:0] data;
    logic [127:0] word;
    logic [127:0] kind;
    logic [127:0] name;
    logic [2047:0] line;
    dac_clk = 1'b0;
    ps_reset = 1'b1;
    cfg = '0;
    mask_model = '0;
    test_errors = 0;
    stray_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    name = "none";
    void'($urandom(24428));
    for (int c = 0; c < `CHANNELS; c++) begin
      scale_model[c] = 0;
      depth_model[c] = 1;
      burst_model[c] = 0;
      sel_model[c] = 0;
      inc_model[c] = '0;
    end
    repeat (5) @(posedge dac_clk);
    #1;
    ps_reset = 1'b0;
    fd = $fopen("bench/transmit_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file bench/transmit_cases.txt");
      stray_errors++;
    end else begin
      while ($fscanf(fd, "%s", word) == 1) begin
        if (word == "#") begin
          void'($fgets(line, fd));
        end else if (word == "test") begin
          void'($fscanf(fd, "%s", name));
          test_errors = 0;
        end else if (word == "write") begin
          void'($fscanf(fd, "%h %h", addr, data));
          drive_write(addr, data);
        end else if (word == "random") begin
          void'($fscanf(fd, "%d %d", ch, count));
          for (int n = 0; n < count; n++) begin
            drive_write('h400 + `WAVE_DEPTH * ch + n, $urandom & 32'hffff);
          end
        end else if (word == "wait") begin
          void'($fscanf(fd, "%d", count));
          repeat (count) next_cycle();
        end else if (word == "expect") begin
          void'($fscanf(fd, "%s", kind));
          if (kind == "idle") begin
            void'($fscanf(fd, "%d", count));
            check_idle(count);
          end else if (kind == "wave") begin
            void'($fscanf(fd, "%d", ch));
            check_wave(ch);
          end else begin
            void'($fscanf(fd, "%d %d", ch, count));
            check_triangle(ch, count);
          end
        end else if (word == "done") begin
          if (test_errors == 0) begin
            $display("test %0s: passed", name);
            tests_passed++;
          end else begin
            $display("test %0s: failed with %0d errors", name, test_errors);
            tests_failed++;
          end
          test_errors = 0;
        end else begin
          $display("unknown record %0s in the case file", word);
          stray_errors++;
        end
      end
      $fclose(fd);
    end
    stray_errors += test_errors;
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && stray_errors == 0 && tests_passed > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: rtl/transmit_top.sv
// top level with the config block and the sample pipeline
// sources, source select, scaler, then DAC outputs
`timescale 1ns/1ns
`include "transmit_settings.svh"

module transmit_top (
  input  logic dac_clk,
  input  logic ps_reset,
  input  transmit_pkg::cfg_write_t cfg,
  output transmit_pkg::sample_t [`CHANNELS-1:0] dac_data,
  output logic [`CHANNELS-1:0] dac_valid,
  output logic dac_trigger
);
  import transmit_pkg::*;

  // configuration outputs
  phase_t [`CHANNELS-1:0] tri_inc;
  source_e [`CHANNELS-1:0] src_sel;
  scale_t [`CHANNELS-1:0] scale;
  depth_t [`CHANNELS-1:0] depth;
  burst_t [`CHANNELS-1:0] burst;
  logic [`CHANNELS-1:0] trig_mask;
  logic [`CHANNELS-1:0] start;
  wave_write_t wave_write;

  // pipeline beats
  stage_beat_t wave_beat;
  stage_beat_t tri_beat;
  stage_beat_t sel_beat;

  config_regs i_regs (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .cfg(cfg),
    .tri_inc(tri_inc),
    .src_sel(src_sel),
    .scale(scale),
    .depth(depth),
    .burst(burst),
    .trig_mask(trig_mask),
    .start(start),
    .wave_write(wave_write)
  );

  waveform_player i_player (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .wave_write(wave_write),
    .start(start),
    .depth(depth),
    .burst(burst),
    .beat(wave_beat)
  );

  triangle_gen i_tri (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .tri_inc(tri_inc),
    .beat(tri_beat)
  );

  source_select i_select (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .wave_beat(wave_beat),
    .tri_beat(tri_beat),
    .src_sel(src_sel),
    .trig_mask(trig_mask),
    .beat(sel_beat)
  );

  sample_scaler i_scaler (
    .dac_clk(dac_clk),
    .ps_reset(ps_reset),
    .beat(sel_beat),
    .scale(scale),
    .dac_data(dac_data),
    .dac_valid(dac_valid),
    .dac_trigger(dac_trigger)
  );

endmodule

// File: rtl/sample_scaler.sv
// per-channel fixed-point gain with saturation
// drives the DAC outputs and the OR of the frame starts as trigger
`timescale 1ns/1ns
`include "transmit_settings.svh"

module sample_scaler (
  input  logic dac_clk,
  input  logic ps_reset,
  input  transmit_pkg::stage_beat_t beat,
  input  transmit_pkg::scale_t [`CHANNELS-1:0] scale,
  output transmit_pkg::sample_t [`CHANNELS-1:0] dac_data,
  output logic [`CHANNELS-1:0] dac_valid,
  output logic dac_trigger
);
  import transmit_pkg::*;

  // signed sample times unsigned scale with a zero sign bit
  localparam int PROD_WIDTH = `SAMPLE_WIDTH + `SCALE_WIDTH + 1;
  localparam int SAMPLE_MAX = 2 ** (`SAMPLE_WIDTH - 1) - 1;
  localparam int SAMPLE_MIN = -(2 ** (`SAMPLE_WIDTH - 1));

  logic signed [PROD_WIDTH-1:0] product [`CHANNELS];
  logic signed [PROD_WIDTH-1:0] shifted [`CHANNELS];
  sample_t [`CHANNELS-1:0] clamped;

  always_comb begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      product[ch] = $signed(beat.sample[ch]) * $signed({1'b0, scale[ch]});
      // arithmetic shift floors toward minus infinity
      shifted[ch] = product[ch] >>> `SCALE_FRAC_BITS;
      if (shifted[ch] > SAMPLE_MAX) begin
        clamped[ch] = sample_t'(SAMPLE_MAX);
      end else if (shifted[ch] < SAMPLE_MIN) begin
        clamped[ch] = sample_t'(SAMPLE_MIN);
      end else begin
        clamped[ch] = sample_t'(shifted[ch]);
      end
    end
  end

  // trigger registered alongside the sample it belongs to
  always_ff @(posedge dac_clk) begin
    if (ps_reset) begin
      dac_data <= '0;
      dac_valid <= '0;
      dac_trigger <= 1'b0;
    end else begin
      dac_data <= clamped;
      dac_valid <= beat.valid;
      dac_trigger <= |beat.frame_start;
    end
  end

  // a trigger always lands on a live sample
  a_trig_has_valid: assert property (
    @(posedge dac_clk) disable iff (ps_reset)
    dac_trigger |-> (|dac_valid)
  );

endmodule

// File: rtl/source_select.sv
// registered per-channel source mux
// frame starts only pass from the waveform source through the trigger mask
`timescale 1ns/1ns
`include "transmit_settings.svh"

module source_select (
  input  logic dac_clk,
  input  logic ps_reset,
  input  transmit_pkg::stage_beat_t wave_beat,
  input  transmit_pkg::stage_beat_t tri_beat,
  input  transmit_pkg::source_e [`CHANNELS-1:0] src_sel,
  input  logic [`CHANNELS-1:0] trig_mask,
  output transmit_pkg::stage_beat_t beat
);
  import transmit_pkg::*;

  sample_t [`CHANNELS-1:0] nxt_sample;
  logic [`CHANNELS-1:0] nxt_valid;
  logic [`CHANNELS-1:0] nxt_start;

  always_comb begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      nxt_start[ch] = 1'b0;
      case (src_sel[ch])
        SRC_WAVE: begin
          nxt_sample[ch] = wave_beat.sample[ch];
          nxt_valid[ch] = wave_beat.valid[ch];
          nxt_start[ch] = wave_beat.frame_start[ch] & trig_mask[ch];
        end
        SRC_TRI: begin
          nxt_sample[ch] = tri_beat.sample[ch];
          nxt_valid[ch] = tri_beat.valid[ch];
        end
        default: begin
          nxt_sample[ch] = '0;
          nxt_valid[ch] = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge dac_clk) begin
    beat.sample <= nxt_sample;
    if (ps_reset) begin
      beat.valid <= '0;
      beat.frame_start <= '0;
    end else begin
      beat.valid <= nxt_valid;
      beat.frame_start <= nxt_start;
    end
  end

endmodule

// File: rtl/triangle_gen.sv
// per-channel triangle phase accumulators
// folds the phase into a triangle from full-scale low to full-scale high
`timescale 1ns/1ns
`include "transmit_settings.svh"

module triangle_gen (
  input  logic dac_clk,
  input  logic ps_reset,
  input  transmit_pkg::phase_t [`CHANNELS-1:0] tri_inc,
  output transmit_pkg::stage_beat_t beat
);
  import transmit_pkg::*;

  phase_t phase [`CHANNELS];
  phase_t phase_next [`CHANNELS];
  sample_t folded [`CHANNELS];
  sample_t [`CHANNELS-1:0] tri_sample;

  logic [`SAMPLE_WIDTH-1:0] ramp [`CHANNELS];

  always_comb begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      phase_next[ch] = phase[ch] + tri_inc[ch];
      // bits below the top bit mirrored on the falling half
      ramp[ch] = phase_next[ch][`PHASE_BITS-2 -: `SAMPLE_WIDTH];
      if (phase_next[ch][`PHASE_BITS-1]) begin
        ramp[ch] = ~ramp[ch];
      end
      // offset binary to two's complement
      folded[ch] = sample_t'({~ramp[ch][`SAMPLE_WIDTH-1], ramp[ch][`SAMPLE_WIDTH-2:0]});
    end
  end

  always_ff @(posedge dac_clk) begin
    if (ps_reset) begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        phase[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        phase[ch] <= phase_next[ch];
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      tri_sample[ch] <= folded[ch];
    end
  end

  // triangle always produces and never marks a frame
  always_comb begin
    beat.sample = tri_sample;
    beat.valid = '1;
    beat.frame_start = '0;
  end

endmodule

// File: rtl/waveform_player.sv
// per-channel waveform sample memory and frame playback FSM
// plays depth-long frames for a burst of frames and marks each frame start
`timescale 1ns/1ns
`include "transmit_settings.svh"

module waveform_player (
  input  logic dac_clk,
  input  logic ps_reset,
  input  transmit_pkg::wave_write_t wave_write,
  input  logic [`CHANNELS-1:0] start,
  input  transmit_pkg::depth_t [`CHANNELS-1:0] depth,
  input  transmit_pkg::burst_t [`CHANNELS-1:0] burst,
  output transmit_pkg::stage_beat_t beat
);
  import transmit_pkg::*;

  sample_t mem [`CHANNELS][`WAVE_DEPTH];

  player_state_e state [`CHANNELS];
  wave_addr_t addr [`CHANNELS];
  burst_t frames [`CHANNELS];

  logic [`CHANNELS-1:0] play_now;
  logic [`CHANNELS-1:0] first_word;
  logic [`CHANNELS-1:0] last_word;
  logic [`CHANNELS-1:0] last_frame;

  // addr sits at 0 while idle, so a start reads word 0 right away
  always_comb begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      play_now[ch] = (state[ch] == PLAY) || (start[ch] && (burst[ch] != '0));
      first_word[ch] = (addr[ch] == '0);
      last_word[ch] = (depth_t'(addr[ch]) + depth_t'(1)) >= depth[ch];
      last_frame[ch] = (frames[ch] + burst_t'(1)) >= burst[ch];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (wave_write.valid) begin
      mem[wave_write.channel][wave_write.addr] <= wave_write.sample;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (ps_reset) begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        state[ch] <= IDLE;
        addr[ch] <= '0;
        frames[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        // a start during PLAY changes nothing here
        if (play_now[ch]) begin
          if (last_word[ch]) begin
            addr[ch] <= '0;
            if (last_frame[ch]) begin
              state[ch] <= IDLE;
              frames[ch] <= '0;
            end else begin
              state[ch] <= PLAY;
              frames[ch] <= frames[ch] + burst_t'(1);
            end
          end else begin
            addr[ch] <= addr[ch] + wave_addr_t'(1);
            state[ch] <= PLAY;
          end
        end
      end
    end
  end

  // registered output beat with a zero sample while idle
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < `CHANNELS; ch++) begin
      beat.sample[ch] <= play_now[ch] ? mem[ch][addr[ch]] : sample_t'(0);
    end
    if (ps_reset) begin
      beat.valid <= '0;
      beat.frame_start <= '0;
    end else begin
      beat.valid <= play_now;
      beat.frame_start <= play_now & first_word;
    end
  end

  for (genvar ch = 0; ch < `CHANNELS; ch++) begin : g_chk
    a_addr_in_frame: assert property (
      @(posedge dac_clk) disable iff (ps_reset)
      (state[ch] == PLAY) |-> (depth_t'(addr[ch]) < depth[ch])
    );
  end

endmodule

// File: rtl/config_regs.sv
// config register block decoding config writes into per-channel settings
// also forwards waveform memory writes and play start pulses
`timescale 1ns/1ns
`include "transmit_settings.svh"

module config_regs (
  input  logic dac_clk,
  input  logic ps_reset,
  input  transmit_pkg::cfg_write_t cfg,
  output transmit_pkg::phase_t [`CHANNELS-1:0] tri_inc,
  output transmit_pkg::source_e [`CHANNELS-1:0] src_sel,
  output transmit_pkg::scale_t [`CHANNELS-1:0] scale,
  output transmit_pkg::depth_t [`CHANNELS-1:0] depth,
  output transmit_pkg::burst_t [`CHANNELS-1:0] burst,
  output logic [`CHANNELS-1:0] trig_mask,
  output logic [`CHANNELS-1:0] start,
  output transmit_pkg::wave_write_t wave_write
);
  import transmit_pkg::*;

  localparam int WAVE_SPAN = `CHANNELS * `WAVE_DEPTH;

  cfg_addr_t wave_offset;
  logic wave_hit;

  // waveform region is channel-major with WAVE_DEPTH words each
  assign wave_offset = cfg.address - ADDR_WAVE_BASE;
  assign wave_hit = cfg.valid && (cfg.address >= ADDR_WAVE_BASE) && (wave_offset < WAVE_SPAN);

  always_ff @(posedge dac_clk) begin
    wave_write.channel <= chan_t'(wave_offset >> $bits(wave_addr_t));
    wave_write.addr <= wave_addr_t'(wave_offset);
    wave_write.sample <= sample_t'(cfg.data[`SAMPLE_WIDTH-1:0]);
    if (ps_reset) begin
      for (int ch = 0; ch < `CHANNELS; ch++) begin
        tri_inc[ch] <= '0;
        src_sel[ch] <= SRC_ZERO;
        scale[ch] <= '0;
        depth[ch] <= depth_t'(1);
        burst[ch] <= '0;
      end
      trig_mask <= '0;
      start <= '0;
      wave_write.valid <= 1'b0;
    end else begin
      // start is a single-cycle pulse
      start <= '0;
      wave_write.valid <= wave_hit;
      if (cfg.valid) begin
        for (int ch = 0; ch < `CHANNELS; ch++) begin
          if (cfg.address == ADDR_TRI_INC + ch) tri_inc[ch] <= phase_t'(cfg.data);
          if (cfg.address == ADDR_SRC_SEL + ch) src_sel[ch] <= source_e'(cfg.data[1:0]);
          if (cfg.address == ADDR_SCALE + ch) scale[ch] <= cfg.data[`SCALE_WIDTH-1:0];
          if (cfg.address == ADDR_DEPTH + ch) depth[ch] <= cfg.data[$bits(depth_t)-1:0];
          if (cfg.address == ADDR_BURST + ch) burst[ch] <= cfg.data[$bits(burst_t)-1:0];
        end
        if (cfg.address == ADDR_TRIG_MASK) trig_mask <= cfg.data[`CHANNELS-1:0];
        if (cfg.address == ADDR_START) start <= cfg.data[`CHANNELS-1:0];
      end
    end
  end

  // decode must never see an unknown address on a live write
  a_cfg_addr_known: assert property (
    @(posedge dac_clk) disable iff (ps_reset)
    cfg.valid |-> !$isunknown(cfg.address)
  );

endmodule

// File: rtl/transmit_pkg.sv
// shared types for the transmit chain
// sample and config typedefs, state enums, pipeline beat structs
`include "transmit_settings.svh"

package transmit_pkg;

  localparam int CHAN_BITS = (`CHANNELS > 1) ? $clog2(`CHANNELS) : 1;

  typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`PHASE_BITS-1:0] phase_t;
  typedef logic [`SCALE_WIDTH-1:0] scale_t;
  typedef logic [$clog2(`WAVE_DEPTH)-1:0] wave_addr_t;
  // one extra bit so a full frame of WAVE_DEPTH fits
  typedef logic [$clog2(`WAVE_DEPTH):0] depth_t;
  typedef logic [15:0] burst_t;
  typedef logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_t;
  typedef logic [CHAN_BITS-1:0] chan_t;

  typedef enum logic [1:0] {SRC_ZERO, SRC_WAVE, SRC_TRI} source_e;
  typedef enum logic {IDLE, PLAY} player_state_e;

  // config address map with per-channel regions at base + ch
  localparam cfg_addr_t ADDR_TRI_INC = 'h000;
  localparam cfg_addr_t ADDR_SRC_SEL = 'h010;
  localparam cfg_addr_t ADDR_SCALE = 'h020;
  localparam cfg_addr_t ADDR_DEPTH = 'h030;
  localparam cfg_addr_t ADDR_BURST = 'h040;
  localparam cfg_addr_t ADDR_TRIG_MASK = 'h050;
  localparam cfg_addr_t ADDR_START = 'h060;
  localparam cfg_addr_t ADDR_WAVE_BASE = 'h400;

  typedef struct packed {
    logic valid;
    cfg_addr_t address;
    logic [31:0] data;
  } cfg_write_t;

  typedef struct packed {
    logic valid;
    chan_t channel;
    wave_addr_t addr;
    sample_t sample;
  } wave_write_t;

  typedef struct packed {
    sample_t [`CHANNELS-1:0] sample;
    logic [`CHANNELS-1:0] valid;
    logic [`CHANNELS-1:0] frame_start;
  } stage_beat_t;

endpackage

// File: rtl/transmit_settings.svh
// sizing macros for the DAC transmit chain
// channel count, sample and phase widths, scale format, waveform depth
`ifndef TRANSMIT_SETTINGS_SVH
`define TRANSMIT_SETTINGS_SVH

// number of DAC channels
`define CHANNELS 2
// DAC sample width
`define SAMPLE_WIDTH 16
// triangle accumulator width
`define PHASE_BITS 32
// scale factor width and fraction bits where 1.0 is 0x10000
`define SCALE_WIDTH 18
`define SCALE_FRAC_BITS 16
// waveform samples per channel
`define WAVE_DEPTH 64
// config bus address width
`define CFG_ADDR_WIDTH 12

`endif
